// ==== hdl/tinker_pkg.sv ====
package tinker_pkg;

    // widths with a meaning
    typedef logic [63:0] word_t;     // register or data value
    typedef logic [31:0] addr_t;     // byte address or pc
    typedef logic [31:0] instr_t;    // raw instruction word
    typedef logic [4:0]  reg_addr_t; // register number
    typedef logic [11:0] literal_t;  // literal field L

    // kept opcodes, reference encodings
    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,  // pc = rd
        op_brr_l  = 5'h0a,  // pc += sext(L) * 4
        op_brnz   = 5'h0b,  // pc = rd if rs != 0
        op_halt   = 5'h0f,
        op_load   = 5'h10,  // rd = mem[rs + L]
        op_mov_rs = 5'h11,
        op_mov_l  = 5'h12,  // low 12 bits of rd = L
        op_store  = 5'h13,  // mem[rd + L] = rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_t;

    // control bundle travelling down the pipe
    typedef struct packed {
        logic reg_write; // result goes to rd
        logic mem_read;  // load
        logic mem_write; // store
        logic is_branch; // resolved in EX
        logic halt;
    } ctrl_t;

    // operand source for the EX muxes
    typedef enum logic [1:0] {
        from_file   = 2'd0,
        from_exmem  = 2'd1,
        from_memwb  = 2'd2
    } fwd_sel_t;

    // mov r0 r0, all register fields zero
    localparam instr_t nop_instr = {op_mov_rs, 27'd0};

    localparam addr_t pc_step       = 32'd4;
    localparam addr_t pc_reset_addr = 32'h0000_2000; // default program start

endpackage

// ==== hdl/tinker_if.sv ====
`timescale 1ns/10ps

// contents of the ID/EX register
interface stage_bus_if;
    tinker_pkg::ctrl_t     ctrl;    // all zero means bubble
    tinker_pkg::opcode_t   opcode;
    tinker_pkg::reg_addr_t rd;
    tinker_pkg::reg_addr_t rs;
    tinker_pkg::reg_addr_t rt;
    tinker_pkg::literal_t  l;
    tinker_pkg::addr_t     pc;
    tinker_pkg::word_t     rd_val;  // register file values, not yet forwarded
    tinker_pkg::word_t     rs_val;
    tinker_pkg::word_t     rt_val;

    modport producer (
        output ctrl, opcode, rd, rs, rt, l, pc, rd_val, rs_val, rt_val
    );

    modport consumer (
        input ctrl, opcode, rd, rs, rt, l, pc, rd_val, rs_val, rt_val
    );
endinterface

// MEM/WB outputs: register write port and halt flag
interface writeback_if;
    logic                  we;    // never set for r0
    tinker_pkg::reg_addr_t rd;
    tinker_pkg::word_t     data;  // load data or ALU result
    logic                  halt;  // halt sits in MEM/WB

    modport source (
        output we, rd, data, halt
    );

    modport sink (
        input we, rd, data, halt
    );
endinterface

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage #(
    parameter tinker_pkg::addr_t PC_RESET_ADDR = tinker_pkg::pc_reset_addr,
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_we,     // program load strobe
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,   // word index
    input  tinker_pkg::instr_t            imem_data,
    input  logic                          stall,       // load-use hold
    input  logic                          halt_seen,
    input  logic                          redirect,    // taken branch in EX
    input  tinker_pkg::addr_t             redirect_pc,
    output tinker_pkg::instr_t            if_id_instr,
    output tinker_pkg::addr_t             if_id_pc
);

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    tinker_pkg::instr_t imem [IMEM_WORDS];
    tinker_pkg::addr_t  pc;
    tinker_pkg::instr_t fetched;
    logic               halt_hold;  // sticky once the halt has passed ID
    logic               freeze;

    // word index wraps inside the memory
    assign fetched = imem[pc[IMEM_AW+1:2]];
    assign freeze  = halt_seen | halt_hold;

    // loaded from outside during reset only
    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_addr] <= imem_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= PC_RESET_ADDR;
            if_id_instr <= tinker_pkg::nop_instr;
            if_id_pc    <= '0;
            halt_hold   <= 1'b0;
        end else begin
            halt_hold <= halt_hold | halt_seen;
            if (redirect) begin
                pc          <= redirect_pc;
                if_id_instr <= tinker_pkg::nop_instr; // squash the one in IF
                if_id_pc    <= redirect_pc;
            end else if (stall) begin
                // hold pc and IF/ID
            end else if (freeze) begin
                if_id_instr <= tinker_pkg::nop_instr; // pc stays put
            end else begin
                pc          <= pc + tinker_pkg::pc_step;
                if_id_instr <= fetched;
                if_id_pc    <= pc;
            end
        end
    end

    // program load only while the core sits in reset
    a_load_in_reset: assert property (@(posedge clk) imem_we |-> reset);

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::instr_t if_id_instr,
    input  tinker_pkg::addr_t  if_id_pc,
    input  logic               redirect,   // squash ID this cycle
    writeback_if.sink          wb,
    output logic               stall,
    output logic               halt_seen,
    stage_bus_if.producer      id_ex
);

    tinker_pkg::opcode_t   opcode;
    tinker_pkg::reg_addr_t rd, rs, rt;
    tinker_pkg::literal_t  l;
    tinker_pkg::ctrl_t     ctrl;
    tinker_pkg::word_t     regs [32];
    tinker_pkg::word_t     rd_val, rs_val, rt_val;

    // field split
    assign opcode = tinker_pkg::opcode_t'(if_id_instr[31:27]);
    assign rd     = if_id_instr[26:22];
    assign rs     = if_id_instr[21:17];
    assign rt     = if_id_instr[16:12];
    assign l      = if_id_instr[11:0];

    always_comb begin
        ctrl = '0; // unknown opcodes act as nop
        case (opcode)
            tinker_pkg::op_add, tinker_pkg::op_addi, tinker_pkg::op_sub,
            tinker_pkg::op_subi, tinker_pkg::op_and, tinker_pkg::op_or,
            tinker_pkg::op_xor, tinker_pkg::op_not, tinker_pkg::op_shftr,
            tinker_pkg::op_shftri, tinker_pkg::op_shftl, tinker_pkg::op_shftli,
            tinker_pkg::op_mov_rs, tinker_pkg::op_mov_l:
                ctrl.reg_write = 1'b1;
            tinker_pkg::op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            tinker_pkg::op_store:
                ctrl.mem_write = 1'b1;
            tinker_pkg::op_br, tinker_pkg::op_brr_l, tinker_pkg::op_brnz:
                ctrl.is_branch = 1'b1;
            tinker_pkg::op_halt:
                ctrl.halt = 1'b1;
            default: ;
        endcase
        if (rd == '0)
            ctrl.reg_write = 1'b0; // r0 stays zero
    end

    // register file, written from MEM/WB
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb.we) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write shows through to the read
    assign rd_val = (wb.we && wb.rd == rd) ? wb.data : regs[rd];
    assign rs_val = (wb.we && wb.rd == rs) ? wb.data : regs[rs];
    assign rt_val = (wb.we && wb.rd == rt) ? wb.data : regs[rt];

    // load in EX feeding any field of ID, conservative
    assign stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                   (id_ex.rd == rs || id_ex.rd == rt || id_ex.rd == rd);

    assign halt_seen = ctrl.halt & ~redirect;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            id_ex.ctrl <= '0;
        else if (redirect || stall)
            id_ex.ctrl <= '0; // bubble
        else
            id_ex.ctrl <= ctrl;
    end

    // payload follows every cycle, ignored under a bubble
    always_ff @(posedge clk) begin
        id_ex.opcode <= opcode;
        id_ex.rd     <= rd;
        id_ex.rs     <= rs;
        id_ex.rt     <= rt;
        id_ex.l      <= l;
        id_ex.pc     <= if_id_pc;
        id_ex.rd_val <= rd_val;
        id_ex.rs_val <= rs_val;
        id_ex.rt_val <= rt_val;
    end

    // r0 writes are stripped in ID, so none may come back
    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        !(wb.we && wb.rd == '0));

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic                  clk,
    input  logic                  reset,
    stage_bus_if.consumer         id_ex,
    writeback_if.sink             wb,             // MEM/WB forwarding source
    output logic                  redirect,       // one-cycle pulse
    output tinker_pkg::addr_t     redirect_pc,
    output tinker_pkg::ctrl_t     ex_mem_ctrl,
    output tinker_pkg::word_t     ex_mem_result,  // ALU value or byte address
    output tinker_pkg::word_t     ex_mem_store_data,
    output tinker_pkg::reg_addr_t ex_mem_rd
);

    tinker_pkg::fwd_sel_t sel_rd, sel_rs, sel_rt;
    tinker_pkg::word_t    rd_v, rs_v, rt_v;    // forwarded operands
    tinker_pkg::word_t    lit;                 // zero-extended L
    tinker_pkg::word_t    result;
    logic                 taken;

    // youngest producer wins; a load in EX/MEM has no data yet
    function automatic tinker_pkg::fwd_sel_t pick(input tinker_pkg::reg_addr_t r);
        if (ex_mem_ctrl.reg_write && !ex_mem_ctrl.mem_read && ex_mem_rd == r)
            return tinker_pkg::from_exmem;
        else if (wb.we && wb.rd == r)
            return tinker_pkg::from_memwb;
        return tinker_pkg::from_file;
    endfunction

    function automatic tinker_pkg::word_t operand(input tinker_pkg::fwd_sel_t sel,
                                                  input tinker_pkg::word_t file_val);
        case (sel)
            tinker_pkg::from_exmem: return ex_mem_result;
            tinker_pkg::from_memwb: return wb.data;
            default:                return file_val;
        endcase
    endfunction

    always_comb begin
        sel_rd = pick(id_ex.rd);
        sel_rs = pick(id_ex.rs);
        sel_rt = pick(id_ex.rt);
        rd_v   = operand(sel_rd, id_ex.rd_val); // literal forms, stores, branches
        rs_v   = operand(sel_rs, id_ex.rs_val);
        rt_v   = operand(sel_rt, id_ex.rt_val);
    end

    assign lit = {52'd0, id_ex.l};

    always_comb begin
        case (id_ex.opcode)
            tinker_pkg::op_add:    result = rs_v + rt_v;
            tinker_pkg::op_addi:   result = rd_v + lit;
            tinker_pkg::op_sub:    result = rs_v - rt_v;
            tinker_pkg::op_subi:   result = rd_v - lit;
            tinker_pkg::op_and:    result = rs_v & rt_v;
            tinker_pkg::op_or:     result = rs_v | rt_v;
            tinker_pkg::op_xor:    result = rs_v ^ rt_v;
            tinker_pkg::op_not:    result = ~rs_v;
            tinker_pkg::op_shftr:  result = rs_v >> rt_v;
            tinker_pkg::op_shftri: result = rd_v >> lit;
            tinker_pkg::op_shftl:  result = rs_v << rt_v;
            tinker_pkg::op_shftli: result = rd_v << lit;
            tinker_pkg::op_mov_rs: result = rs_v;
            tinker_pkg::op_mov_l:  result = {rd_v[63:12], id_ex.l}; // keep upper bits
            tinker_pkg::op_load:   result = rs_v + lit;            // address
            tinker_pkg::op_store:  result = rd_v + lit;            // address
            default:               result = '0;
        endcase
    end

    // branch decision on forwarded values
    always_comb begin
        taken       = 1'b0;
        redirect_pc = rd_v[31:0];
        case (id_ex.opcode)
            tinker_pkg::op_br:   taken = 1'b1;
            tinker_pkg::op_brnz: taken = (rs_v != '0);
            tinker_pkg::op_brr_l: begin
                taken       = 1'b1;
                redirect_pc = id_ex.pc + {{18{id_ex.l[11]}}, id_ex.l, 2'b00};
            end
            default: ;
        endcase
    end

    assign redirect = id_ex.ctrl.is_branch & taken; // bubbles never branch

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            ex_mem_ctrl <= '0;
        else
            ex_mem_ctrl <= id_ex.ctrl; // always advances
    end

    always_ff @(posedge clk) begin
        ex_mem_result     <= result;
        ex_mem_store_data <= rs_v;     // mov (rd)(L), rs
        ex_mem_rd         <= id_ex.rd;
    end

endmodule

// ==== hdl/memory_stage.sv ====
`timescale 1ns/10ps

module memory_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  reset,
    input  tinker_pkg::ctrl_t     ex_mem_ctrl,
    input  tinker_pkg::word_t     ex_mem_result,
    input  tinker_pkg::word_t     ex_mem_store_data,
    input  tinker_pkg::reg_addr_t ex_mem_rd,
    writeback_if.source           wb,
    output logic                  halted
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    tinker_pkg::word_t   dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0]  word_idx;   // byte address / 8
    tinker_pkg::word_t   load_data;
    logic                halt_hold;

    assign word_idx  = ex_mem_result[DMEM_AW+2:3];
    assign load_data = dmem[word_idx]; // combinational read

    always_ff @(posedge clk) begin
        if (ex_mem_ctrl.mem_write)
            dmem[word_idx] <= ex_mem_store_data;
    end

    // MEM/WB register, always advances
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb.we   <= 1'b0;
            wb.halt <= 1'b0;
        end else begin
            wb.we   <= ex_mem_ctrl.reg_write;
            wb.halt <= ex_mem_ctrl.halt;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd   <= ex_mem_rd;
        wb.data <= ex_mem_ctrl.mem_read ? load_data : ex_mem_result;
    end

    // sticky until reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            halt_hold <= 1'b0;
        else if (wb.halt)
            halt_hold <= 1'b1;
    end

    assign halted = wb.halt | halt_hold; // high from the cycle halt sits in MEM/WB

    // word-aligned loads and stores only
    a_aligned: assert property (@(posedge clk) disable iff (reset)
        (ex_mem_ctrl.mem_read || ex_mem_ctrl.mem_write) |-> ex_mem_result[2:0] == 3'b000);

endmodule

// ==== hdl/tinker_core.sv ====
`timescale 1ns/10ps

module tinker_core #(
    parameter tinker_pkg::addr_t PC_RESET_ADDR = tinker_pkg::pc_reset_addr,
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  tinker_pkg::instr_t            imem_data,
    output logic                          wb_valid,   // one pulse per retired write
    output tinker_pkg::reg_addr_t         wb_rd,
    output tinker_pkg::word_t             wb_data,
    output logic                          halted
);

    tinker_pkg::instr_t    if_id_instr;
    tinker_pkg::addr_t     if_id_pc;
    logic                  stall, halt_seen, redirect;
    tinker_pkg::addr_t     redirect_pc;
    tinker_pkg::ctrl_t     ex_mem_ctrl;
    tinker_pkg::word_t     ex_mem_result, ex_mem_store_data;
    tinker_pkg::reg_addr_t ex_mem_rd;

    stage_bus_if id_ex_bus ();
    writeback_if wb_bus ();

    // input side
    fetch_stage #(
        .PC_RESET_ADDR (PC_RESET_ADDR),
        .IMEM_WORDS    (IMEM_WORDS)
    ) fetch_stage_inst (
        .clk, .reset, .imem_we, .imem_addr, .imem_data,
        .stall, .halt_seen, .redirect, .redirect_pc,
        .if_id_instr, .if_id_pc
    );

    // processing
    decode_stage decode_stage_inst (
        .clk, .reset, .if_id_instr, .if_id_pc, .redirect,
        .wb (wb_bus.sink), .stall, .halt_seen, .id_ex (id_ex_bus.producer)
    );

    execute_stage execute_stage_inst (
        .clk, .reset, .id_ex (id_ex_bus.consumer), .wb (wb_bus.sink),
        .redirect, .redirect_pc, .ex_mem_ctrl, .ex_mem_result,
        .ex_mem_store_data, .ex_mem_rd
    );

    // output side
    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) memory_stage_inst (
        .clk, .reset, .ex_mem_ctrl, .ex_mem_result, .ex_mem_store_data,
        .ex_mem_rd, .wb (wb_bus.source), .halted
    );

    assign wb_valid = wb_bus.we;
    assign wb_rd    = wb_bus.rd;
    assign wb_data  = wb_bus.data;

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== verification/tinker_model.svh ====
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

localparam int STEP_LIMIT = 2000; // model gives up after this many instructions

// one retired register write
typedef struct packed {
    tinker_pkg::reg_addr_t rd;
    tinker_pkg::word_t     data;
} exp_write_t;

tinker_pkg::instr_t prog [$];  // word 0 sits at PC_BASE
exp_write_t         exp_q [$]; // writes in program order with r0 left out

function automatic void emit(input tinker_pkg::opcode_t op, input int rd, input int rs,
                             input int rt, input int lit);
    prog.push_back({op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)});
endfunction

// absolute pc of word idx into register r
function automatic void emit_target(input int r, input int idx);
    emit(tinker_pkg::op_xor, r, r, r, 0);
    emit(tinker_pkg::op_mov_l, r, 0, 0, PC_BASE >> 2);
    emit(tinker_pkg::op_shftli, r, 0, 0, 2);
    emit(tinker_pkg::op_addi, r, 0, 0, idx * 4);
endfunction

function automatic void build_program();
    tinker_pkg::opcode_t alu_ops [14];
    tinker_pkg::opcode_t op;
    int                  lit;
    int                  tgt;
    alu_ops = '{tinker_pkg::op_add, tinker_pkg::op_addi, tinker_pkg::op_sub,
                tinker_pkg::op_subi, tinker_pkg::op_and, tinker_pkg::op_or,
                tinker_pkg::op_xor, tinker_pkg::op_not, tinker_pkg::op_shftr,
                tinker_pkg::op_shftri, tinker_pkg::op_shftl, tinker_pkg::op_shftli,
                tinker_pkg::op_mov_rs, tinker_pkg::op_mov_l};
    prog.delete();
    // seeds r1..r7 spread over the upper bits
    for (int r = 1; r <= 7; r++) begin
        emit(tinker_pkg::op_mov_l, r, 0, 0, next_rand());
        emit(tinker_pkg::op_shftli, r, 0, 0, next_rand() % 52);
        emit(tinker_pkg::op_mov_l, r, 0, 0, next_rand());
    end
    // random ALU ops from r1..r7 into r8..r15
    for (int i = 0; i < 40; i++) begin
        if (i < 14)
            op = alu_ops[i];               // every op at least once
        else
            op = alu_ops[next_rand() % 14];
        lit = next_rand() % 4096;
        if (op == tinker_pkg::op_shftri || op == tinker_pkg::op_shftli)
            lit = lit % 64;
        emit(op, 8 + next_rand() % 8, 1 + next_rand() % 7, 1 + next_rand() % 7, lit);
    end
    emit(tinker_pkg::op_add, 0, 1, 2, 0);   // dropped so r0 stays zero
    emit(tinker_pkg::op_add, 8, 0, 1, 0);
    // small register shift amounts
    emit(tinker_pkg::op_xor, 20, 20, 20, 0);
    emit(tinker_pkg::op_mov_l, 20, 0, 0, next_rand() % 64);
    emit(tinker_pkg::op_shftl, 18, 1, 20, 0);
    emit(tinker_pkg::op_shftr, 19, 2, 20, 0);
    // producer to consumer at distance d
    for (int d = 1; d <= 3; d++) begin
        emit(tinker_pkg::op_add, 16, 1, 2, 0);
        for (int f = 1; f < d; f++)
            emit(tinker_pkg::op_xor, 22, 3, 4, 0); // filler
        emit(tinker_pkg::op_sub, 17, 16, 3, 0);
        emit(tinker_pkg::op_or, 19, 4, 16, 0);     // rt side one further
        emit(tinker_pkg::op_addi, 16, 0, 0, next_rand() % 4096);
        emit(tinker_pkg::op_mov_rs, 18, 16, 0, 0);
    end
    // store then load with the data used at once
    emit(tinker_pkg::op_xor, 24, 24, 24, 0);
    emit(tinker_pkg::op_mov_l, 24, 0, 0, 'h100);
    emit(tinker_pkg::op_store, 24, 5, 0, 8);
    emit(tinker_pkg::op_load, 25, 24, 0, 8);
    emit(tinker_pkg::op_add, 26, 25, 1, 0);
    emit(tinker_pkg::op_store, 24, 6, 0, 16);
    emit(tinker_pkg::op_load, 27, 24, 0, 16);
    emit(tinker_pkg::op_addi, 27, 0, 0, 3);      // loaded reg as rd operand
    emit(tinker_pkg::op_load, 25, 24, 0, 8);
    emit(tinker_pkg::op_xor, 22, 3, 4, 0);
    emit(tinker_pkg::op_sub, 26, 25, 27, 0);     // load two back
    // brr_l over one marker
    emit(tinker_pkg::op_brr_l, 0, 0, 0, 2);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h111);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h222);
    // br over two markers
    tgt = prog.size() + 7;
    emit_target(29, tgt);
    emit(tinker_pkg::op_br, 29, 0, 0, 0);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h333);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h444);
    // brnz taken and then not taken on r0
    emit(tinker_pkg::op_mov_l, 30, 0, 0, 7);
    tgt = prog.size() + 7;
    emit_target(29, tgt);
    emit(tinker_pkg::op_brnz, 29, 30, 0, 0);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h555);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h666);
    emit(tinker_pkg::op_brnz, 29, 0, 0, 0);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'h777);
    // countdown loop where brnz reads the subi right before it
    emit(tinker_pkg::op_xor, 21, 21, 21, 0);
    emit(tinker_pkg::op_mov_l, 21, 0, 0, 3);
    emit_target(23, prog.size() + 4);
    emit(tinker_pkg::op_addi, 22, 0, 0, 1);
    emit(tinker_pkg::op_subi, 21, 0, 0, 1);
    emit(tinker_pkg::op_brnz, 23, 21, 0, 0);
    emit(tinker_pkg::op_halt, 0, 0, 0, 0);
    emit(tinker_pkg::op_mov_l, 28, 0, 0, 'hbad); // behind the halt
endfunction

// ISA-order execution that fills exp_q and returns whether halt was reached
function automatic bit run_model();
    tinker_pkg::word_t     r [32];
    tinker_pkg::word_t     mem [tinker_pkg::word_t]; // keyed by byte address / 8
    tinker_pkg::instr_t    ins;
    tinker_pkg::reg_addr_t rd, rs, rt;
    tinker_pkg::word_t     lit, res;
    int                    idx, cur, off;
    bit                    wr;
    exp_q.delete();
    foreach (r[i])
        r[i] = '0;
    idx = 0;
    for (int step = 0; step < STEP_LIMIT; step++) begin
        if (idx < 0 || idx >= prog.size())
            return 1'b0; // ran off the program
        cur = idx;
        ins = prog[cur];
        rd  = ins[26:22];
        rs  = ins[21:17];
        rt  = ins[16:12];
        lit = {52'd0, ins[11:0]};
        off = $signed(ins[11:0]);
        res = '0;
        wr  = 1'b1;
        idx = cur + 1;
        case (tinker_pkg::opcode_t'(ins[31:27]))
            tinker_pkg::op_add:    res = r[rs] + r[rt];
            tinker_pkg::op_addi:   res = r[rd] + lit;
            tinker_pkg::op_sub:    res = r[rs] - r[rt];
            tinker_pkg::op_subi:   res = r[rd] - lit;
            tinker_pkg::op_and:    res = r[rs] & r[rt];
            tinker_pkg::op_or:     res = r[rs] | r[rt];
            tinker_pkg::op_xor:    res = r[rs] ^ r[rt];
            tinker_pkg::op_not:    res = ~r[rs];
            tinker_pkg::op_shftr:  res = r[rs] >> r[rt];
            tinker_pkg::op_shftri: res = r[rd] >> lit;
            tinker_pkg::op_shftl:  res = r[rs] << r[rt];
            tinker_pkg::op_shftli: res = r[rd] << lit;
            tinker_pkg::op_mov_rs: res = r[rs];
            tinker_pkg::op_mov_l:  res = {r[rd][63:12], ins[11:0]};
            tinker_pkg::op_load:
                res = mem.exists((r[rs] + lit) >> 3) ? mem[(r[rs] + lit) >> 3] : '0;
            tinker_pkg::op_store: begin
                mem[(r[rd] + lit) >> 3] = r[rs];
                wr = 1'b0;
            end
            tinker_pkg::op_br: begin
                idx = int'((r[rd][31:0] - PC_BASE) >> 2);
                wr  = 1'b0;
            end
            tinker_pkg::op_brr_l: begin
                idx = cur + off; // offset in words
                wr  = 1'b0;
            end
            tinker_pkg::op_brnz: begin
                if (r[rs] != '0)
                    idx = int'((r[rd][31:0] - PC_BASE) >> 2);
                wr = 1'b0;
            end
            tinker_pkg::op_halt:   return 1'b1;
            default:               wr = 1'b0; // nop
        endcase
        if (wr && rd != '0) begin
            r[rd] = res;
            exp_q.push_back('{rd, res});
        end
    end
    return 1'b0;
endfunction

`endif

// ==== verification/tinker_tb.sv ====
`timescale 1ns/10ps

module tinker_tb;

    localparam tinker_pkg::addr_t PC_BASE = tinker_pkg::pc_reset_addr;
    localparam int IMEM_WORDS   = 256;
    localparam int IMEM_AW      = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS   = 256;
    localparam int RESET_CYCLES = 5;
    localparam int HALT_LIMIT   = 4000; // cycles for the whole program
    localparam int QUIET_CYCLES = 20;   // watched after halt

    logic                  clk;
    logic                  reset;
    logic                  imem_we;
    logic [IMEM_AW-1:0]    imem_addr;
    tinker_pkg::instr_t    imem_data;
    logic                  wb_valid;
    tinker_pkg::reg_addr_t wb_rd;
    tinker_pkg::word_t     wb_data;
    logic                  halted;

    int          value_errors; // wrong values
    int          other_errors; // timeouts, missing or extra writes
    logic [31:0] lcg_state;
    bit          model_halts;

    clock_gen clock_gen_inst (.clk);

    tinker_core #(
        .PC_RESET_ADDR (PC_BASE),
        .IMEM_WORDS    (IMEM_WORDS),
        .DMEM_WORDS    (DMEM_WORDS)
    ) tinker_core_inst (
        .clk, .reset, .imem_we, .imem_addr, .imem_data,
        .wb_valid, .wb_rd, .wb_data, .halted
    );

    // 32-bit LCG with numerical recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "tinker_model.svh"

    task automatic check_reg_write(input tinker_pkg::reg_addr_t exp_rd,
                                   input tinker_pkg::word_t exp_data);
        if (wb_rd !== exp_rd) begin
            value_errors++;
            $display("[ERROR] wb_rd: expected 0x%h, got 0x%h", exp_rd, wb_rd);
        end
        if (wb_data !== exp_data) begin
            value_errors++;
            $display("[ERROR] wb_data (r%0d): expected 0x%h, got 0x%h", exp_rd, exp_data,
                     wb_data);
        end
    endtask

    task automatic check_halted(input logic expected);
        if (halted !== expected) begin
            value_errors++;
            $display("[ERROR] halted: expected 0x%h, got 0x%h", expected, halted);
        end
    endtask

    // one expected write popped per wb_valid pulse at mid-cycle
    always @(negedge clk) begin : compare_writes
        exp_write_t expected;
        if (!reset && wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("write to r%0d arrived after the model ran out of writes", wb_rd);
            end else begin
                expected = exp_q.pop_front();
                check_reg_write(expected.rd, expected.data);
            end
        end
    end

    initial begin : stimulus
        int cycles;
        reset        = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        value_errors = 0;
        other_errors = 0;
        lcg_state    = 32'hbb83b2f2;

        build_program();
        model_halts = run_model();
        if (!model_halts) begin
            other_errors++;
            $display("reference model never reached the halt");
        end
        if (prog.size() > IMEM_WORDS) begin
            other_errors++;
            $display("program of %0d words does not fit in the instruction memory",
                     prog.size());
        end

        // program goes in while the core is held in reset
        for (int i = 0; i < prog.size() && i < IMEM_WORDS; i++) begin
            @(negedge clk);
            imem_we   = 1'b1;
            imem_addr = i[IMEM_AW-1:0];
            imem_data = prog[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        if (wb_valid !== 1'b0) begin
            value_errors++;
            $display("[ERROR] wb_valid: expected 0x0, got 0x%h", wb_valid);
        end
        check_halted(1'b0);

        cycles = 0;
        while (halted !== 1'b1 && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            other_errors++;
            $display("halted never rose within %0d cycles", HALT_LIMIT);
        end

        // any pulse in this window is caught by compare_writes
        for (cycles = 0; cycles < QUIET_CYCLES; cycles++)
            @(negedge clk);
        check_halted(model_halts);
        @(posedge clk); // after the last compare at negedge
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected register writes never arrived", exp_q.size());
        end

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verification
hdl/tinker_pkg.sv
hdl/tinker_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/tinker_core.sv
verification/clock_gen.sv
verification/tinker_tb.sv

// ==== Bender.yml ====
package:
  name: tinker_core

sources:
  - files:
      - hdl/tinker_pkg.sv
      - hdl/tinker_if.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/tinker_core.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/clock_gen.sv
      - verification/tinker_tb.sv
